/* addr_translate.sv */
`default_nettype none

module addr_translate
    import mmu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire csr_state_t           csr_i,
    input  wire search_req_t          inst_req_i,
    input  wire search_req_t          data_req_i,
    input  wire tlb_cmd_t             tlb_cmd_i,
    output search_rsp_t               inst_rsp_o,
    output search_rsp_t               data_rsp_o,
    output search_rsp_t               srch_rsp_o,
    output tlb_read_t                 read_o,
    output logic [TLB_IDX_W-1:0]      fill_index_o,
    output logic                      s0_fetch_o,
    output logic [VPPN_W-1:0]         s0_vppn_o,
    output logic                      s0_odd_o,
    output logic                      s1_fetch_o,
    output logic [VPPN_W-1:0]         s1_vppn_o,
    output logic                      s1_odd_o,
    output logic [ASID_W-1:0]         asid_o,
    input  wire logic                 s0_hit_i,
    input  wire tlb_entry_t           s0_ent_i,
    input  wire logic                 s1_hit_i,
    input  wire logic [TLB_IDX_W-1:0] s1_idx_i,
    input  wire tlb_entry_t           s1_ent_i,
    output logic                      we_o,
    output logic [TLB_IDX_W-1:0]      w_index_o,
    output tlb_entry_t                w_entry_o,
    output logic [TLB_IDX_W-1:0]      r_index_o,
    input  wire tlb_entry_t           r_entry_i,
    output tlb_cmd_t                  inv_o
);

    // mode is decided at the strobe so a held response stays put
    typedef struct packed {
        logic        paged;
        logic [31:0] vaddr;
        logic [19:0] dtag;
    } req_buf_t;

    req_buf_t             inst_buf_q;
    req_buf_t             data_buf_q;
    logic                 inst_vld_q;
    logic                 data_vld_q;
    logic                 data_take;
    logic                 s1_srch_q;
    search_rsp_t          data_live;
    search_rsp_t          srch_live;
    search_rsp_t          data_hold_q;
    search_rsp_t          srch_hold_q;
    logic [TLB_IDX_W-1:0] fill_cnt_q;

    function automatic req_buf_t classify(csr_state_t csr, logic [31:0] va);
        req_buf_t b;
        logic     pg_mode;
        logic     dmw0_hit;
        logic     dmw1_hit;
        pg_mode  = !csr.da && csr.pg;
        dmw0_hit = pg_mode && csr.dmw0[PLV0_POS] && csr.dmw0[VSEG_POS +: 3] == va[31:29];
        dmw1_hit = pg_mode && csr.dmw1[PLV0_POS] && csr.dmw1[VSEG_POS +: 3] == va[31:29];
        b.vaddr  = va;
        b.paged  = pg_mode && !dmw0_hit && !dmw1_hit;
        if (dmw0_hit) begin
            b.dtag = {csr.dmw0[PSEG_POS +: 3], va[28:12]};
        end else if (dmw1_hit) begin
            b.dtag = {csr.dmw1[PSEG_POS +: 3], va[28:12]};
        end else begin
            b.dtag = va[31:12];
        end
        return b;
    endfunction

    // entry attributes only for paged requests that hit
    function automatic search_rsp_t form_rsp(req_buf_t b, logic vld, logic hit,
                                             tlb_entry_t ent, logic [TLB_IDX_W-1:0] idx);
        search_rsp_t r;
        r     = '0;
        r.tag = b.dtag;
        if (b.paged && hit) begin
            r.found = 1'b1;
            r.index = idx;
            r.v     = ent.v0;
            r.d     = ent.d0;
            r.plv   = ent.plv0;
            r.mat   = ent.mat0;
            r.tag   = (ent.ps == PS_4M) ? {ent.ppn0[19:10], b.vaddr[21:12]} : ent.ppn0;
        end
        if (!vld) begin
            r = '0;
        end
        return r;
    endfunction

    function automatic logic [31:0] pack_elo(logic v, logic d, logic [1:0] plv,
                                             logic [1:0] mat, logic g, logic [PPN_W-1:0] ppn);
        logic [31:0] elo;
        elo                      = '0;
        elo[V_POS]               = v;
        elo[D_POS]               = d;
        elo[PLV_POS +: 2]        = plv;
        elo[MAT_POS +: 2]        = mat;
        elo[G_POS]               = g;
        elo[PPN_POS +: PPN_W]    = ppn;
        return elo;
    endfunction

    // tlb search owns port 1 for its cycle and drops a data strobe then
    assign data_take = data_req_i.fetch && !tlb_cmd_i.srch;

    assign s0_fetch_o = inst_req_i.fetch;
    assign s0_vppn_o  = inst_req_i.vaddr[31:VPPN_POS];
    assign s0_odd_o   = inst_req_i.vaddr[12];
    assign s1_fetch_o = data_take || tlb_cmd_i.srch;
    assign s1_vppn_o  = tlb_cmd_i.srch ? csr_i.tlbehi[VPPN_POS +: VPPN_W]
                                       : data_req_i.vaddr[31:VPPN_POS];
    assign s1_odd_o   = tlb_cmd_i.srch ? 1'b0 : data_req_i.vaddr[12];
    assign asid_o     = csr_i.asid;

    always_ff @(posedge clk) begin
        if (inst_req_i.fetch) begin
            inst_buf_q <= classify(csr_i, inst_req_i.vaddr);
        end
        if (data_take) begin
            data_buf_q <= classify(csr_i, data_req_i.vaddr);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_vld_q  <= 1'b0;
            data_vld_q  <= 1'b0;
            s1_srch_q   <= 1'b0;
            data_hold_q <= '0;
            srch_hold_q <= '0;
            fill_cnt_q  <= '0;
        end else begin
            if (inst_req_i.fetch) begin
                inst_vld_q <= 1'b1;
            end
            if (data_take) begin
                data_vld_q <= 1'b1;
            end
            if (s1_fetch_o) begin
                s1_srch_q <= tlb_cmd_i.srch;
            end
            data_hold_q <= data_rsp_o;
            srch_hold_q <= srch_rsp_o;
            if (tlb_cmd_i.fill) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
            end
        end
    end

    assign inst_rsp_o = form_rsp(inst_buf_q, inst_vld_q, s0_hit_i, s0_ent_i, '0);
    assign data_live  = form_rsp(data_buf_q, data_vld_q, s1_hit_i, s1_ent_i, s1_idx_i);
    assign data_rsp_o = s1_srch_q ? data_hold_q : data_live;

    always_comb begin
        srch_live       = '0;
        srch_live.found = s1_hit_i;
        srch_live.index = s1_idx_i;
    end

    assign srch_rsp_o = s1_srch_q ? srch_live : srch_hold_q;

    assign we_o         = tlb_cmd_i.wr || tlb_cmd_i.fill;
    assign w_index_o    = tlb_cmd_i.fill ? fill_cnt_q : csr_i.tlbidx[INDEX_POS +: TLB_IDX_W];
    assign fill_index_o = fill_cnt_q;
    assign inv_o        = tlb_cmd_i;

    always_comb begin
        w_entry_o.e    = !csr_i.tlbidx[NE_POS];
        w_entry_o.asid = csr_i.asid;
        w_entry_o.g    = csr_i.tlbelo0[G_POS] && csr_i.tlbelo1[G_POS];
        w_entry_o.ps   = csr_i.tlbidx[PS_POS +: PS_W];
        w_entry_o.vppn = csr_i.tlbehi[VPPN_POS +: VPPN_W];
        w_entry_o.v0   = csr_i.tlbelo0[V_POS];
        w_entry_o.d0   = csr_i.tlbelo0[D_POS];
        w_entry_o.plv0 = csr_i.tlbelo0[PLV_POS +: 2];
        w_entry_o.mat0 = csr_i.tlbelo0[MAT_POS +: 2];
        w_entry_o.ppn0 = csr_i.tlbelo0[PPN_POS +: PPN_W];
        w_entry_o.v1   = csr_i.tlbelo1[V_POS];
        w_entry_o.d1   = csr_i.tlbelo1[D_POS];
        w_entry_o.plv1 = csr_i.tlbelo1[PLV_POS +: 2];
        w_entry_o.mat1 = csr_i.tlbelo1[MAT_POS +: 2];
        w_entry_o.ppn1 = csr_i.tlbelo1[PPN_POS +: PPN_W];
    end

    // read data in csr layout with the index field left zero
    assign r_index_o = csr_i.tlbidx[INDEX_POS +: TLB_IDX_W];

    always_comb begin
        read_o                           = '0;
        read_o.ehi[VPPN_POS +: VPPN_W]   = r_entry_i.vppn;
        read_o.elo0 = pack_elo(r_entry_i.v0, r_entry_i.d0, r_entry_i.plv0, r_entry_i.mat0,
                               r_entry_i.g, r_entry_i.ppn0);
        read_o.elo1 = pack_elo(r_entry_i.v1, r_entry_i.d1, r_entry_i.plv1, r_entry_i.mat1,
                               r_entry_i.g, r_entry_i.ppn1);
        read_o.idx[NE_POS]               = !r_entry_i.e;
        read_o.idx[PS_POS +: PS_W]       = r_entry_i.ps;
        read_o.asid                      = r_entry_i.asid;
    end

    a_one_cmd: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0({tlb_cmd_i.wr, tlb_cmd_i.fill, tlb_cmd_i.srch, tlb_cmd_i.inv}));

endmodule

`default_nettype wire

/* mmu_csr.sv */
`default_nettype none

module mmu_csr
    import mmu_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset_i,
    input  wire csr_wr_t csr_wr_i,
    output csr_state_t   state_o
);

    csr_state_t state_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= '0;
        end else if (csr_wr_i.we) begin
            case (csr_wr_i.addr)
                CSR_ASID: begin
                    state_q.asid <= csr_wr_i.data[ASID_W-1:0];
                end
                CSR_CRMD: begin
                    // only the translation mode bits live here
                    state_q.da <= csr_wr_i.data[DA_POS];
                    state_q.pg <= csr_wr_i.data[PG_POS];
                end
                CSR_DMW0: begin
                    state_q.dmw0 <= csr_wr_i.data & DMW_MASK;
                end
                CSR_DMW1: begin
                    state_q.dmw1 <= csr_wr_i.data & DMW_MASK;
                end
                CSR_TLBEHI: begin
                    state_q.tlbehi <= csr_wr_i.data & TLBEHI_MASK;
                end
                CSR_TLBELO0: begin
                    state_q.tlbelo0 <= csr_wr_i.data & TLBELO_MASK;
                end
                CSR_TLBELO1: begin
                    state_q.tlbelo1 <= csr_wr_i.data & TLBELO_MASK;
                end
                CSR_TLBIDX: begin
                    state_q.tlbidx <= csr_wr_i.data & TLBIDX_MASK;
                end
                default: begin
                    state_q <= state_q;
                end
            endcase
        end
    end

    assign state_o = state_q;

    a_csr_addr_known: assert property (@(posedge clk) disable iff (reset_i)
        csr_wr_i.we |-> !$isunknown(csr_wr_i.addr));

endmodule

`default_nettype wire

/* mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    localparam int TLB_NUM   = 16;
    localparam int TLB_IDX_W = 4;
    localparam int ASID_W    = 10;
    localparam int VPPN_W    = 19;
    localparam int PPN_W     = 20;
    localparam int PS_W      = 6;

    localparam logic [PS_W-1:0] PS_4K = 6'd12;
    localparam logic [PS_W-1:0] PS_4M = 6'd21;

    // crmd
    localparam int DA_POS = 3;
    localparam int PG_POS = 4;

    // tlbehi and tlbidx
    localparam int VPPN_POS  = 13;
    localparam int PS_POS    = 24;
    localparam int NE_POS    = 31;
    localparam int INDEX_POS = 0;

    // tlbelo0/1
    localparam int V_POS   = 0;
    localparam int D_POS   = 1;
    localparam int PLV_POS = 2;
    localparam int MAT_POS = 4;
    localparam int G_POS   = 6;
    localparam int PPN_POS = 8;

    // dmw0/1
    localparam int PLV0_POS = 0;
    localparam int PSEG_POS = 25;
    localparam int VSEG_POS = 29;

    // writable bits of each register
    localparam logic [31:0] DMW_MASK    = 32'hee00_0039;
    localparam logic [31:0] TLBEHI_MASK = 32'hffff_e000;
    localparam logic [31:0] TLBELO_MASK = 32'h0fff_ff7f;
    localparam logic [31:0] TLBIDX_MASK = 32'hbf00_000f;

    typedef enum logic [2:0] {
        CSR_ASID,
        CSR_CRMD,
        CSR_DMW0,
        CSR_DMW1,
        CSR_TLBEHI,
        CSR_TLBELO0,
        CSR_TLBELO1,
        CSR_TLBIDX
    } csr_addr_e;

    typedef enum logic [2:0] {
        INV_ALL       = 3'd0,
        INV_ALL_ALT   = 3'd1,
        INV_G         = 3'd2,
        INV_NG        = 3'd3,
        INV_NG_ASID   = 3'd4,
        INV_NG_ASD_VA = 3'd5,
        INV_ASID_VA   = 3'd6
    } inv_op_e;

    typedef struct packed {
        logic              e;
        logic [ASID_W-1:0] asid;
        logic              g;
        logic [PS_W-1:0]   ps;
        logic [VPPN_W-1:0] vppn;
        logic              v0;
        logic              d0;
        logic [1:0]        plv0;
        logic [1:0]        mat0;
        logic [PPN_W-1:0]  ppn0;
        logic              v1;
        logic              d1;
        logic [1:0]        plv1;
        logic [1:0]        mat1;
        logic [PPN_W-1:0]  ppn1;
    } tlb_entry_t;

    typedef struct packed {
        logic        we;
        csr_addr_e   addr;
        logic [31:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic [ASID_W-1:0] asid;
        logic              da;
        logic              pg;
        logic [31:0]       dmw0;
        logic [31:0]       dmw1;
        logic [31:0]       tlbehi;
        logic [31:0]       tlbelo0;
        logic [31:0]       tlbelo1;
        logic [31:0]       tlbidx;
    } csr_state_t;

    typedef struct packed {
        logic        fetch;
        logic [31:0] vaddr;
    } search_req_t;

    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        logic                 v;
        logic                 d;
        logic [1:0]           plv;
        logic [1:0]           mat;
        logic [19:0]          tag;
    } search_rsp_t;

    typedef struct packed {
        logic              wr;
        logic              fill;
        logic              srch;
        logic              inv;
        inv_op_e           op;
        logic [ASID_W-1:0] asid;
        logic [31:0]       va;
    } tlb_cmd_t;

    typedef struct packed {
        logic [31:0]       ehi;
        logic [31:0]       elo0;
        logic [31:0]       elo1;
        logic [31:0]       idx;
        logic [ASID_W-1:0] asid;
    } tlb_read_t;

endpackage

`default_nettype wire

/* mmu_tb_model.svh */
`ifndef MMU_TB_MODEL_SVH
`define MMU_TB_MODEL_SVH

// reference copy of the registers and the tlb
csr_state_t           ref_csr;
tlb_entry_t           ref_tlb [TLB_NUM];
bit                   ref_written [TLB_NUM];
logic [TLB_IDX_W-1:0] ref_fill;
search_rsp_t          exp_inst;
search_rsp_t          exp_data;
search_rsp_t          exp_srch;

task automatic reset_model();
    ref_csr  = '0;
    ref_fill = '0;
    exp_inst = '0;
    exp_data = '0;
    exp_srch = '0;
    for (int i = 0; i < TLB_NUM; i++) begin
        ref_tlb[i]     = '0;
        ref_written[i] = 1'b0;
    end
endtask

task automatic apply_csr_write(input csr_wr_t w);
    case (w.addr)
        CSR_ASID:    ref_csr.asid = w.data[ASID_W-1:0];
        CSR_CRMD: begin
            ref_csr.da = w.data[3];
            ref_csr.pg = w.data[4];
        end
        CSR_DMW0:    ref_csr.dmw0 = w.data & DMW_MASK;
        CSR_DMW1:    ref_csr.dmw1 = w.data & DMW_MASK;
        CSR_TLBEHI:  ref_csr.tlbehi = w.data & TLBEHI_MASK;
        CSR_TLBELO0: ref_csr.tlbelo0 = w.data & TLBELO_MASK;
        CSR_TLBELO1: ref_csr.tlbelo1 = w.data & TLBELO_MASK;
        default:     ref_csr.tlbidx = w.data & TLBIDX_MASK;
    endcase
endtask

// 4M pages only look at va[31:22]
function automatic logic same_page(tlb_entry_t ent, logic [18:0] vppn);
    if (ent.ps == PS_4M) begin
        return ent.vppn[18:9] == vppn[18:9];
    end
    return ent.vppn == vppn;
endfunction

function automatic int find_entry(logic [18:0] vppn, logic [ASID_W-1:0] asid);
    int found;
    found = -1;
    for (int i = 0; i < TLB_NUM; i++) begin
        if (ref_tlb[i].e && (ref_tlb[i].g || ref_tlb[i].asid == asid)
                && same_page(ref_tlb[i], vppn)) begin
            found = i;
        end
    end
    return found;
endfunction

function automatic search_rsp_t expect_translation(logic [31:0] va, logic with_index);
    search_rsp_t r;
    int          hit;
    tlb_entry_t  ent;
    logic        odd;
    logic [19:0] ppn;
    r     = '0;
    r.tag = va[31:12];
    if (!ref_csr.pg || ref_csr.da) begin
        return r;
    end
    if (ref_csr.dmw0[0] && ref_csr.dmw0[31:29] == va[31:29]) begin
        r.tag[19:17] = ref_csr.dmw0[27:25];
        return r;
    end
    if (ref_csr.dmw1[0] && ref_csr.dmw1[31:29] == va[31:29]) begin
        r.tag[19:17] = ref_csr.dmw1[27:25];
        return r;
    end
    hit = find_entry(va[31:13], ref_csr.asid);
    if (hit < 0) begin
        return r;
    end
    ent     = ref_tlb[hit];
    odd     = (ent.ps == PS_4M) ? va[21] : va[12];
    ppn     = odd ? ent.ppn1 : ent.ppn0;
    r.found = 1'b1;
    r.index = with_index ? TLB_IDX_W'(hit) : '0;
    r.v     = odd ? ent.v1 : ent.v0;
    r.d     = odd ? ent.d1 : ent.d0;
    r.plv   = odd ? ent.plv1 : ent.plv0;
    r.mat   = odd ? ent.mat1 : ent.mat0;
    r.tag   = (ent.ps == PS_4M) ? {ppn[19:10], va[21:12]} : ppn;
    return r;
endfunction

function automatic tlb_entry_t entry_from_csrs();
    tlb_entry_t n;
    n.e    = !ref_csr.tlbidx[31];
    n.asid = ref_csr.asid;
    n.g    = ref_csr.tlbelo0[6] && ref_csr.tlbelo1[6];
    n.ps   = ref_csr.tlbidx[29:24];
    n.vppn = ref_csr.tlbehi[31:13];
    n.v0   = ref_csr.tlbelo0[0];
    n.d0   = ref_csr.tlbelo0[1];
    n.plv0 = ref_csr.tlbelo0[3:2];
    n.mat0 = ref_csr.tlbelo0[5:4];
    n.ppn0 = ref_csr.tlbelo0[27:8];
    n.v1   = ref_csr.tlbelo1[0];
    n.d1   = ref_csr.tlbelo1[1];
    n.plv1 = ref_csr.tlbelo1[3:2];
    n.mat1 = ref_csr.tlbelo1[5:4];
    n.ppn1 = ref_csr.tlbelo1[27:8];
    return n;
endfunction

// two live entries that some lookup could hit together
function automatic logic overlaps_other(tlb_entry_t n, int idx);
    logic [18:0] mask;
    for (int i = 0; i < TLB_NUM; i++) begin
        mask = (n.ps == PS_4M || ref_tlb[i].ps == PS_4M) ? 19'h7fe00 : 19'h7ffff;
        if (i != idx && n.e && ref_tlb[i].e
                && (n.g || ref_tlb[i].g || n.asid == ref_tlb[i].asid)
                && (n.vppn & mask) == (ref_tlb[i].vppn & mask)) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic logic inv_selects(tlb_entry_t ent, tlb_cmd_t cmd);
    logic asid_eq;
    logic va_eq;
    asid_eq = ent.asid == cmd.asid;
    va_eq   = same_page(ent, cmd.va[31:13]);
    case (cmd.op)
        INV_G:         return ent.g;
        INV_NG:        return !ent.g;
        INV_NG_ASID:   return !ent.g && asid_eq;
        INV_NG_ASD_VA: return !ent.g && asid_eq && va_eq;
        INV_ASID_VA:   return (ent.g || asid_eq) && va_eq;
        default:       return 1'b1;
    endcase
endfunction

function automatic tlb_read_t expected_read(tlb_entry_t ent);
    tlb_read_t r;
    r             = '0;
    r.ehi[31:13]  = ent.vppn;
    r.elo0        = {4'b0, ent.ppn0, 1'b0, ent.g, ent.mat0, ent.plv0, ent.d0, ent.v0};
    r.elo1        = {4'b0, ent.ppn1, 1'b0, ent.g, ent.mat1, ent.plv1, ent.d1, ent.v1};
    r.idx[31]     = !ent.e;
    r.idx[29:24]  = ent.ps;
    r.asid        = ent.asid;
    return r;
endfunction

// one clock edge: lookups see the old state, updates land afterwards
task automatic advance_model(input csr_wr_t w, input search_req_t ireq,
                             input search_req_t dreq, input tlb_cmd_t cmd);
    tlb_entry_t n;
    int         hit;
    if (ireq.fetch) begin
        exp_inst = expect_translation(ireq.vaddr, 1'b0);
    end
    if (cmd.srch) begin
        hit            = find_entry(ref_csr.tlbehi[31:13], ref_csr.asid);
        exp_srch       = '0;
        exp_srch.found = hit >= 0;
        exp_srch.index = (hit >= 0) ? TLB_IDX_W'(hit) : '0;
    end else if (dreq.fetch) begin
        exp_data = expect_translation(dreq.vaddr, 1'b1);
    end
    n = entry_from_csrs();
    if (cmd.wr) begin
        ref_tlb[ref_csr.tlbidx[3:0]]     = n;
        ref_written[ref_csr.tlbidx[3:0]] = 1'b1;
    end
    if (cmd.fill) begin
        ref_tlb[ref_fill]     = n;
        ref_written[ref_fill] = 1'b1;
        ref_fill              = ref_fill + 1'b1;
    end
    if (cmd.inv) begin
        for (int i = 0; i < TLB_NUM; i++) begin
            if (inv_selects(ref_tlb[i], cmd)) begin
                ref_tlb[i].e = 1'b0;
            end
        end
    end
    if (w.we) begin
        apply_csr_write(w);
    end
endtask

`endif

/* mmu_tb.sv */
`default_nettype none

module mmu_tb
    import mmu_pkg::*;
();

    localparam int          CLK_PERIOD    = 8;
    localparam int          RESET_CYCLES  = 10;
    localparam int          RUN_CYCLES    = 2000;
    localparam int          WATCHDOG_TIME = 2100 * CLK_PERIOD;
    localparam int unsigned SEED          = 32'hd923_1aa4;

    logic                 clk;
    logic                 reset_i;
    csr_wr_t              csr_wr;
    search_req_t          inst_req;
    search_req_t          data_req;
    tlb_cmd_t             tlb_cmd;
    search_rsp_t          inst_rsp;
    search_rsp_t          data_rsp;
    tlb_read_t            read_data;
    search_rsp_t          srch_rsp;
    logic [TLB_IDX_W-1:0] fill_index;

    int errors;
    int checks;

    `include "mmu_tb_model.svh"

    mmu_top i_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .csr_wr_i     (csr_wr),
        .inst_req_i   (inst_req),
        .data_req_i   (data_req),
        .tlb_cmd_i    (tlb_cmd),
        .inst_rsp_o   (inst_rsp),
        .data_rsp_o   (data_rsp),
        .read_o       (read_data),
        .srch_rsp_o   (srch_rsp),
        .fill_index_o (fill_index)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before the test sequence completed");
        $display("Finished with errors");
        $finish;
    end

    task automatic clear_inputs();
        csr_wr   = '0;
        inst_req = '0;
        data_req = '0;
        tlb_cmd  = '0;
    endtask

    // small pools keep hits frequent
    function automatic logic [31:0] pick_va();
        logic [31:0] va;
        va = $urandom();
        case ($urandom_range(0, 3))
            0:       va[31:22] = 10'h001;
            1:       va[31:22] = 10'h0a5;
            2:       va[31:22] = 10'h2f0;
            default: va[31:22] = 10'h3ff;
        endcase
        va[20:13] = $urandom_range(0, 1) ? 8'h3c : 8'h00;
        return va;
    endfunction

    function automatic logic [ASID_W-1:0] pick_asid();
        case ($urandom_range(0, 2))
            0:       return 10'h000;
            1:       return 10'h005;
            default: return 10'h13a;
        endcase
    endfunction

    function automatic logic [31:0] random_csr_data(csr_addr_e addr);
        logic [31:0] d;
        d = $urandom();
        case (addr)
            CSR_ASID: d[ASID_W-1:0] = pick_asid();
            CSR_CRMD: begin
                d[3] = $urandom_range(0, 3) == 0;
                d[4] = $urandom_range(0, 3) != 0;
            end
            CSR_TLBEHI: d = pick_va();
            CSR_TLBIDX: begin
                d[31]    = $urandom_range(0, 3) == 0;
                d[29:24] = ($urandom_range(0, 3) == 0) ? PS_4M : PS_4K;
            end
            default: d = d;
        endcase
        return d;
    endfunction

    task automatic drive_random_cycle();
        int roll;
        clear_inputs();
        if ($urandom_range(0, 9) < 4) begin
            csr_wr.we   = 1'b1;
            csr_wr.addr = csr_addr_e'($urandom_range(0, 7));
            csr_wr.data = random_csr_data(csr_wr.addr);
        end
        if ($urandom_range(0, 19) < 7) begin
            roll = $urandom_range(0, 9);
            // writes that would leave two entries hitting one page are dropped
            if (roll < 3) begin
                tlb_cmd.wr = !overlaps_other(entry_from_csrs(), ref_csr.tlbidx[3:0]);
            end else if (roll < 6) begin
                tlb_cmd.fill = !overlaps_other(entry_from_csrs(), ref_fill);
            end else if (roll < 8) begin
                tlb_cmd.srch = 1'b1;
            end else begin
                tlb_cmd.inv  = 1'b1;
                tlb_cmd.op   = ($urandom_range(0, 15) == 0) ? inv_op_e'($urandom_range(0, 1))
                                                            : inv_op_e'($urandom_range(2, 6));
                tlb_cmd.asid = pick_asid();
                tlb_cmd.va   = pick_va();
            end
        end
        inst_req.fetch = $urandom_range(0, 9) < 6;
        inst_req.vaddr = pick_va();
        data_req.fetch = $urandom_range(0, 9) < 6;
        data_req.vaddr = pick_va();
    endtask

    task automatic check_rsp(input string port, input search_rsp_t exp, input search_rsp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s response expected %h got %h", $time, port, exp, act);
        end
    endtask

    task automatic check_outputs();
        logic [TLB_IDX_W-1:0] idx;
        tlb_read_t            exp_rd;
        check_rsp("inst", exp_inst, inst_rsp);
        check_rsp("data", exp_data, data_rsp);
        check_rsp("search", exp_srch, srch_rsp);
        checks++;
        if (fill_index !== ref_fill) begin
            errors++;
            $display("[FAIL] %0t: fill index expected %0d got %0d", $time, ref_fill, fill_index);
        end
        // entries never written hold unknown fields
        idx = ref_csr.tlbidx[3:0];
        if (ref_written[idx]) begin
            checks++;
            exp_rd = expected_read(ref_tlb[idx]);
            if (read_data !== exp_rd) begin
                errors++;
                $display("[FAIL] %0t: read of entry %0d expected %h got %h",
                         $time, idx, exp_rd, read_data);
            end
        end
    endtask

    initial begin
        void'($urandom(SEED));
        errors   = 0;
        checks   = 0;
        clear_inputs();
        reset_model();
        reset_i = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // entries come up unknown and are all cleared first
        tlb_cmd.inv = 1'b1;
        tlb_cmd.op  = INV_ALL;
        @(posedge clk);
        advance_model(csr_wr, inst_req, data_req, tlb_cmd);
        #1;
        check_outputs();

        repeat (RUN_CYCLES) begin
            drive_random_cycle();
            @(posedge clk);
            advance_model(csr_wr, inst_req, data_req, tlb_cmd);
            #1;
            check_outputs();
        end
        clear_inputs();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mmu_top.sv */
`default_nettype none

module mmu_top
    import mmu_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reset_i,
    input  wire csr_wr_t         csr_wr_i,
    input  wire search_req_t     inst_req_i,
    input  wire search_req_t     data_req_i,
    input  wire tlb_cmd_t        tlb_cmd_i,
    output search_rsp_t          inst_rsp_o,
    output search_rsp_t          data_rsp_o,
    output tlb_read_t            read_o,
    output search_rsp_t          srch_rsp_o,
    output logic [TLB_IDX_W-1:0] fill_index_o
);

    csr_state_t           csr_state;
    logic                 s0_fetch;
    logic [VPPN_W-1:0]    s0_vppn;
    logic                 s0_odd;
    logic                 s1_fetch;
    logic [VPPN_W-1:0]    s1_vppn;
    logic                 s1_odd;
    logic [ASID_W-1:0]    asid;
    logic                 s0_hit;
    tlb_entry_t           s0_ent;
    logic                 s1_hit;
    logic [TLB_IDX_W-1:0] s1_idx;
    tlb_entry_t           s1_ent;
    logic                 we;
    logic [TLB_IDX_W-1:0] w_index;
    tlb_entry_t           w_entry;
    logic [TLB_IDX_W-1:0] r_index;
    tlb_entry_t           r_entry;
    tlb_cmd_t             inv_cmd;

    mmu_csr i_csr (
        .clk      (clk),
        .reset_i  (reset_i),
        .csr_wr_i (csr_wr_i),
        .state_o  (csr_state)
    );

    addr_translate i_translate (
        .clk          (clk),
        .reset_i      (reset_i),
        .csr_i        (csr_state),
        .inst_req_i   (inst_req_i),
        .data_req_i   (data_req_i),
        .tlb_cmd_i    (tlb_cmd_i),
        .inst_rsp_o   (inst_rsp_o),
        .data_rsp_o   (data_rsp_o),
        .srch_rsp_o   (srch_rsp_o),
        .read_o       (read_o),
        .fill_index_o (fill_index_o),
        .s0_fetch_o   (s0_fetch),
        .s0_vppn_o    (s0_vppn),
        .s0_odd_o     (s0_odd),
        .s1_fetch_o   (s1_fetch),
        .s1_vppn_o    (s1_vppn),
        .s1_odd_o     (s1_odd),
        .asid_o       (asid),
        .s0_hit_i     (s0_hit),
        .s0_ent_i     (s0_ent),
        .s1_hit_i     (s1_hit),
        .s1_idx_i     (s1_idx),
        .s1_ent_i     (s1_ent),
        .we_o         (we),
        .w_index_o    (w_index),
        .w_entry_o    (w_entry),
        .r_index_o    (r_index),
        .r_entry_i    (r_entry),
        .inv_o        (inv_cmd)
    );

    tlb_entry_array i_array (
        .clk        (clk),
        .s0_fetch_i (s0_fetch),
        .s0_vppn_i  (s0_vppn),
        .s0_odd_i   (s0_odd),
        .s1_fetch_i (s1_fetch),
        .s1_vppn_i  (s1_vppn),
        .s1_odd_i   (s1_odd),
        .asid_i     (asid),
        .s0_hit_o   (s0_hit),
        .s0_ent_o   (s0_ent),
        .s1_hit_o   (s1_hit),
        .s1_idx_o   (s1_idx),
        .s1_ent_o   (s1_ent),
        .we_i       (we),
        .w_index_i  (w_index),
        .w_entry_i  (w_entry),
        .r_index_i  (r_index),
        .r_entry_o  (r_entry),
        .inv_i      (inv_cmd)
    );

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
mmu_pkg.sv
tlb_entry_array.sv
mmu_csr.sv
addr_translate.sv
mmu_top.sv
mmu_tb.sv

/* tlb_entry_array.sv */
`default_nettype none

module tlb_entry_array
    import mmu_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 s0_fetch_i,
    input  wire logic [VPPN_W-1:0]    s0_vppn_i,
    input  wire logic                 s0_odd_i,
    input  wire logic                 s1_fetch_i,
    input  wire logic [VPPN_W-1:0]    s1_vppn_i,
    input  wire logic                 s1_odd_i,
    input  wire logic [ASID_W-1:0]    asid_i,
    output logic                      s0_hit_o,
    output tlb_entry_t                s0_ent_o,
    output logic                      s1_hit_o,
    output logic [TLB_IDX_W-1:0]      s1_idx_o,
    output tlb_entry_t                s1_ent_o,
    input  wire logic                 we_i,
    input  wire logic [TLB_IDX_W-1:0] w_index_i,
    input  wire tlb_entry_t           w_entry_i,
    input  wire logic [TLB_IDX_W-1:0] r_index_i,
    output tlb_entry_t                r_entry_o,
    input  wire tlb_cmd_t             inv_i
);

    tlb_entry_t entries [TLB_NUM];

    logic [TLB_NUM-1:0]   s0_match;
    logic [TLB_NUM-1:0]   s1_match;
    logic [TLB_NUM-1:0]   inv_kill;
    tlb_entry_t           s0_ent_c;
    tlb_entry_t           s1_ent_c;
    logic [TLB_IDX_W-1:0] s1_idx_c;

    // large pages compare only va[31:22]
    function automatic logic vppn_eq(tlb_entry_t ent, logic [VPPN_W-1:0] vppn);
        if (ent.ps == PS_4M) begin
            return ent.vppn[VPPN_W-1:9] == vppn[VPPN_W-1:9];
        end
        return ent.vppn == vppn;
    endfunction

    function automatic logic hit(tlb_entry_t ent, logic [VPPN_W-1:0] vppn,
                                 logic [ASID_W-1:0] asid);
        return ent.e && (ent.g || ent.asid == asid) && vppn_eq(ent, vppn);
    endfunction

    // chosen page half comes back in the even slot
    function automatic tlb_entry_t pick_half(tlb_entry_t ent, logic [VPPN_W-1:0] vppn,
                                             logic odd);
        tlb_entry_t res;
        logic       sel;
        res = ent;
        sel = (ent.ps == PS_4M) ? vppn[PS_4M - VPPN_POS] : odd;
        if (sel) begin
            res.v0   = ent.v1;
            res.d0   = ent.d1;
            res.plv0 = ent.plv1;
            res.mat0 = ent.mat1;
            res.ppn0 = ent.ppn1;
        end
        return res;
    endfunction

    function automatic logic inv_match(tlb_entry_t ent, tlb_cmd_t cmd);
        logic asid_eq;
        logic va_eq;
        asid_eq = ent.asid == cmd.asid;
        va_eq   = vppn_eq(ent, cmd.va[31:VPPN_POS]);
        case (cmd.op)
            INV_ALL, INV_ALL_ALT: return 1'b1;
            INV_G:                return ent.g;
            INV_NG:               return !ent.g;
            INV_NG_ASID:          return !ent.g && asid_eq;
            INV_NG_ASD_VA:        return !ent.g && asid_eq && va_eq;
            INV_ASID_VA:          return (ent.g || asid_eq) && va_eq;
            default:              return 1'b0;
        endcase
    endfunction

    always_comb begin
        s0_ent_c = '0;
        s1_ent_c = '0;
        s1_idx_c = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            s0_match[i] = hit(entries[i], s0_vppn_i, asid_i);
            s1_match[i] = hit(entries[i], s1_vppn_i, asid_i);
            inv_kill[i] = inv_match(entries[i], inv_i);
            if (s0_match[i]) begin
                s0_ent_c = pick_half(entries[i], s0_vppn_i, s0_odd_i);
            end
            if (s1_match[i]) begin
                s1_ent_c = pick_half(entries[i], s1_vppn_i, s1_odd_i);
                s1_idx_c = TLB_IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s0_fetch_i) begin
            s0_hit_o <= |s0_match;
            s0_ent_o <= s0_ent_c;
        end
        if (s1_fetch_i) begin
            s1_hit_o <= |s1_match;
            s1_idx_o <= s1_idx_c;
            s1_ent_o <= s1_ent_c;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < TLB_NUM; i++) begin
            if (we_i && w_index_i == TLB_IDX_W'(i)) begin
                entries[i] <= w_entry_i;
            end else if (inv_i.inv && inv_kill[i]) begin
                entries[i].e <= 1'b0;
            end
        end
    end

    assign r_entry_o = entries[r_index_i];

    // duplicate entries would make the one-hot encode above ambiguous
    a_s0_single_hit: assert property (@(posedge clk) s0_fetch_i |-> $onehot0(s0_match));
    a_s1_single_hit: assert property (@(posedge clk) s1_fetch_i |-> $onehot0(s1_match));

endmodule

`default_nettype wire
